/* include/ssi_rx_defines.svh */
`ifndef SSI_RX_DEFINES_SVH
`define SSI_RX_DEFINES_SVH

// lane word size, one SSI sample per lane
`define SSI_WORD_W 16

// sample buffer entries
`define SSI_FIFO_DEPTH 4

// accepted sample counter
`define SSI_CNT_W 16

`endif

/* rtl/ssi_rx_pkg.sv */
`include "ssi_rx_defines.svh"

package ssi_rx_pkg;

  // **************************************************
  // lane and sample types
  // **************************************************

  // one serial lane word, MSB first on the wire
  typedef logic [`SSI_WORD_W-1:0] lane_word_t;

  // I in the upper half, matches the output tdata layout
  typedef struct packed {
    lane_word_t i;
    lane_word_t q;
  } iq_sample_t;

endpackage

/* rtl/ssi_lane_deser.sv */
`timescale 1ns/1ps
`include "ssi_rx_defines.svh"

module ssi_lane_deser
  import ssi_rx_pkg::*;
(
  input  logic       dclk_i,
  input  logic       rst_n_i,
  input  logic       strobe_i,
  input  logic       lane_i,
  output lane_word_t word_o,
  output logic       word_valid_o
);

  localparam int CNT_W = $clog2(`SSI_WORD_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SSI_WORD_W - 1);

  logic [CNT_W-1:0] bit_cnt_q; // bits already taken
  logic             busy_q;

  // strobe edge takes bit 15, shifting stops once the word is full
  always_ff @(posedge dclk_i) begin
    if (strobe_i || busy_q) begin
      word_o <= {word_o[`SSI_WORD_W-2:0], lane_i};
    end
  end

  always_ff @(posedge dclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      bit_cnt_q    <= '0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= 1'b0;
      if (strobe_i) begin
        // restart, partial word is lost
        busy_q    <= 1'b1;
        bit_cnt_q <= CNT_W'(1);
      end else if (busy_q) begin
        bit_cnt_q <= bit_cnt_q + CNT_W'(1);
        if (bit_cnt_q == LAST_BIT) begin
          busy_q       <= 1'b0;
          word_valid_o <= 1'b1; // bit 0 just taken
        end
      end
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // a word needs a fresh strobe and 16 edges, so pulses never touch
  a_single_pulse: assert property (
    @(posedge dclk_i) disable iff (!rst_n_i)
    word_valid_o |=> !word_valid_o
  );

endmodule

/* rtl/ssi_sample_pack.sv */
`timescale 1ns/1ps
`include "ssi_rx_defines.svh"

module ssi_sample_pack
  import ssi_rx_pkg::*;
(
  input  logic                  dclk_i,
  input  logic                  rst_n_i,
  input  logic                  strobe_i,
  input  logic                  enable_i,
  input  lane_word_t            i_word_i,
  input  lane_word_t            q_word_i,
  input  logic                  i_valid_i,
  input  logic                  q_valid_i,
  input  logic                  wr_ready_i,
  output iq_sample_t            sample_o,
  output logic                  sample_valid_o,
  output logic                  overflow_o,
  output logic [`SSI_CNT_W-1:0] sample_cnt_o
);

  logic enable_q;  // enable seen at the last strobe
  logic word_pair;

  assign word_pair = i_valid_i & q_valid_i;

  // payload register, only loaded when both lanes finish
  always_ff @(posedge dclk_i) begin
    if (word_pair) begin
      sample_o.i <= i_word_i;
      sample_o.q <= q_word_i;
    end
  end

  // **************************************************
  // enable, write strobe, count and overflow
  // **************************************************

  always_ff @(posedge dclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q       <= 1'b0;
      sample_valid_o <= 1'b0;
      overflow_o     <= 1'b0;
      sample_cnt_o   <= '0;
    end else begin
      if (strobe_i) begin
        enable_q <= enable_i;
      end

      // disabled samples never reach the buffer
      sample_valid_o <= word_pair & enable_q;

      if (sample_valid_o && wr_ready_i) begin
        sample_cnt_o <= sample_cnt_o + 1'b1;
      end

      // the link can't stall, so a full buffer loses the sample
      if (sample_valid_o && !wr_ready_i) begin
        overflow_o <= 1'b1; // sticky until reset
      end
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // both lanes share the strobe, so both deserializers finish together
  a_lanes_aligned: assert property (
    @(posedge dclk_i) disable iff (!rst_n_i)
    i_valid_i == q_valid_i
  );

endmodule

/* rtl/sample_fifo.sv */
`timescale 1ns/1ps
`include "ssi_rx_defines.svh"

module sample_fifo
  import ssi_rx_pkg::*;
#(
  parameter type T     = iq_sample_t,
  parameter int  DEPTH = `SSI_FIFO_DEPTH
) (
  input  logic dclk_i,
  input  logic rst_n_i,
  input  T     wr_data_i,
  input  logic wr_valid_i,
  output logic wr_ready_o,
  output T     rd_data_o,
  output logic rd_valid_o,
  input  logic rd_ready_i
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] occ_q;    // entries held, output register included
  logic             wr_en;
  logic             rd_en;
  logic             load;
  logic             mem_empty;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign wr_ready_o = (occ_q < CNT_W'(DEPTH));
  assign wr_en      = wr_valid_i & wr_ready_o;
  assign rd_en      = rd_valid_o & rd_ready_i;
  assign mem_empty  = (occ_q == CNT_W'(rd_valid_o));
  assign load       = !mem_empty && (!rd_valid_o || rd_ready_i); // refill output reg

  always_ff @(posedge dclk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
    if (load) begin
      rd_data_o <= mem_q[rd_ptr_q];
    end
  end

  always_ff @(posedge dclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      occ_q      <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (wr_en) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (load) begin
        rd_ptr_q   <= ptr_next(rd_ptr_q);
        rd_valid_o <= 1'b1;
      end else if (rd_en) begin
        rd_valid_o <= 1'b0;
      end
      occ_q <= occ_q + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // a write into a full buffer would push the count past DEPTH
  a_no_overfill: assert property (
    @(posedge dclk_i) disable iff (!rst_n_i)
    occ_q <= CNT_W'(DEPTH)
  );

  a_hold_on_stall: assert property (
    @(posedge dclk_i) disable iff (!rst_n_i)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o)
  );

endmodule

/* rtl/ssi_rx_top.sv */
`timescale 1ns/1ps
`include "ssi_rx_defines.svh"

module ssi_rx_top
  import ssi_rx_pkg::*;
(
  input  logic                    dclk_i,
  input  logic                    rst_n_i,
  input  logic                    strobe_i,
  input  logic                    idata_i,
  input  logic                    qdata_i,
  input  logic                    enable_i,
  output logic [2*`SSI_WORD_W-1:0] m_tdata_o,
  output logic                    m_tvalid_o,
  input  logic                    m_tready_i,
  output logic                    overflow_o,
  output logic [`SSI_CNT_W-1:0]    sample_cnt_o
);

  lane_word_t i_word;
  lane_word_t q_word;
  logic       i_valid;
  logic       q_valid;
  iq_sample_t sample;
  logic       sample_valid;
  logic       wr_ready;
  iq_sample_t fifo_data;

  // **************************************************
  // lane deserializers
  // **************************************************

  ssi_lane_deser i_deser_inst (
    .dclk_i       (dclk_i),
    .rst_n_i      (rst_n_i),
    .strobe_i     (strobe_i),
    .lane_i       (idata_i),
    .word_o       (i_word),
    .word_valid_o (i_valid)
  );

  ssi_lane_deser q_deser_inst (
    .dclk_i       (dclk_i),
    .rst_n_i      (rst_n_i),
    .strobe_i     (strobe_i),
    .lane_i       (qdata_i),
    .word_o       (q_word),
    .word_valid_o (q_valid)
  );

  ssi_sample_pack ssi_sample_pack_inst (
    .dclk_i         (dclk_i),
    .rst_n_i        (rst_n_i),
    .strobe_i       (strobe_i),
    .enable_i       (enable_i),
    .i_word_i       (i_word),
    .q_word_i       (q_word),
    .i_valid_i      (i_valid),
    .q_valid_i      (q_valid),
    .wr_ready_i     (wr_ready),
    .sample_o       (sample),
    .sample_valid_o (sample_valid),
    .overflow_o     (overflow_o),
    .sample_cnt_o   (sample_cnt_o)
  );

  sample_fifo #(
    .T (iq_sample_t)
  ) sample_fifo_inst (
    .dclk_i     (dclk_i),
    .rst_n_i    (rst_n_i),
    .wr_data_i  (sample),
    .wr_valid_i (sample_valid),
    .wr_ready_o (wr_ready),
    .rd_data_o  (fifo_data),
    .rd_valid_o (m_tvalid_o),
    .rd_ready_i (m_tready_i)
  );

  assign m_tdata_o = fifo_data; // {i, q} flat

endmodule

/* dv/tb_ssi_rx.sv */
`timescale 1ns/1ps
`include "ssi_rx_defines.svh"

module tb_ssi_rx;

  localparam int DATA_W  = 2 * `SSI_WORD_W;
  localparam int TIMEOUT = 2000;

  logic                  dclk_i;
  logic                  rst_n_i;
  logic                  strobe_i;
  logic                  idata_i;
  logic                  qdata_i;
  logic                  enable_i;
  logic [DATA_W-1:0]     m_tdata_o;
  logic                  m_tvalid_o;
  logic                  m_tready_i;
  logic                  overflow_o;
  logic [`SSI_CNT_W-1:0] sample_cnt_o;

  logic [31:0]           lfsr_q;
  logic [DATA_W-1:0]     ref_q [$];  // samples still owed by the DUT in arrival order
  logic [DATA_W-1:0]     exp_head;
  logic                  ref_empty;
  logic [`SSI_CNT_W-1:0] exp_cnt;
  logic [DATA_W-1:0]     held_data;  // tdata one edge back
  logic                  xfer_q;
  logic                  ready_rand;
  logic                  ovf_allowed;
  logic                  chk_reset;
  logic                  chk_cnt;

  ssi_rx_top ssi_rx_top_inst (
    .dclk_i       (dclk_i),
    .rst_n_i      (rst_n_i),
    .strobe_i     (strobe_i),
    .idata_i      (idata_i),
    .qdata_i      (qdata_i),
    .enable_i     (enable_i),
    .m_tdata_o    (m_tdata_o),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .overflow_o   (overflow_o),
    .sample_cnt_o (sample_cnt_o)
  );

  initial dclk_i = 1'b0;
  always #20 dclk_i = ~dclk_i;

  always @(posedge dclk_i) begin
    held_data <= m_tdata_o;
    xfer_q    <= rst_n_i && m_tvalid_o && m_tready_i;
  end

  // **************************************************
  // helpers
  // **************************************************

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic update_head();
    ref_empty = (ref_q.size() == 0);
    exp_head  = ref_empty ? '0 : ref_q[0];
  endtask

  task automatic push_expected(input logic [DATA_W-1:0] s);
    ref_q.push_back(s);
    exp_cnt = exp_cnt + 1'b1;
    update_head();
  endtask

  // retire the last transfer and drive ready on one falling edge
  task automatic tick();
    logic [31:0] r;
    @(negedge dclk_i);
    if (xfer_q && ref_q.size() > 0) begin
      void'(ref_q.pop_front());
    end
    update_head();
    if (ready_rand) begin
      r          = rand_bits(1);
      m_tready_i = r[0];
    end
  endtask

  // MSB first on both lanes with the strobe on the first bit
  task automatic send_sample(input logic [DATA_W-1:0] s, input int nbits, input logic en);
    for (int b = 0; b < nbits; b++) begin
      tick();
      strobe_i = (b == 0);
      enable_i = (b == 0) ? en : !en;  // only the strobe edge should count
      idata_i  = s[DATA_W-1-b];
      qdata_i  = s[`SSI_WORD_W-1-b];
    end
    tick();
    strobe_i = 1'b0;
    idata_i  = 1'b0;
    qdata_i  = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((ref_q.size() != 0 || m_tvalid_o) && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (n >= TIMEOUT) report_error("output stream did not drain in time");
  endtask

  task automatic wait_overflow();
    int n;
    n = 0;
    while (!overflow_o && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (n >= TIMEOUT) report_error("overflow flag never went high with the buffer full");
  endtask

  task automatic check_count();
    tick();
    chk_cnt = 1'b1;
    tick();
    chk_cnt = 1'b0;
  endtask

  // **************************************************
  // checks
  // **************************************************

  a_expected: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    m_tvalid_o && m_tready_i |-> !ref_empty)
    else report_error("a sample came out that was never expected");

  a_data: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    m_tvalid_o && m_tready_i && !ref_empty |-> m_tdata_o == exp_head)
    else report_mismatch("m_tdata_o", $sampled(exp_head), $sampled(m_tdata_o));

  a_hold_valid: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o)
    else report_mismatch("m_tvalid_o", 32'd1, $sampled(m_tvalid_o));

  a_hold_data: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    m_tvalid_o && !m_tready_i |=> m_tdata_o == held_data)
    else report_mismatch("m_tdata_o", $sampled(held_data), $sampled(m_tdata_o));

  a_ovf_sticky: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    overflow_o |=> overflow_o)
    else report_mismatch("overflow_o", 32'd1, $sampled(overflow_o));

  a_no_ovf: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    !ovf_allowed |-> !overflow_o)
    else report_mismatch("overflow_o", 32'd0, $sampled(overflow_o));

  a_count: assert property (@(posedge dclk_i) disable iff (!rst_n_i)
    chk_cnt |-> sample_cnt_o == exp_cnt)
    else report_mismatch("sample_cnt_o", $sampled(exp_cnt), $sampled(sample_cnt_o));

  a_reset_valid: assert property (@(posedge dclk_i) chk_reset |-> !m_tvalid_o)
    else report_mismatch("m_tvalid_o", 32'd0, $sampled(m_tvalid_o));

  a_reset_ovf: assert property (@(posedge dclk_i) chk_reset |-> !overflow_o)
    else report_mismatch("overflow_o", 32'd0, $sampled(overflow_o));

  a_reset_cnt: assert property (@(posedge dclk_i) chk_reset |-> sample_cnt_o == '0)
    else report_mismatch("sample_cnt_o", 32'd0, $sampled(sample_cnt_o));

  // **************************************************
  // stimulus
  // **************************************************

  initial begin
    logic [31:0] s;
    lfsr_q      = 32'h2c08;
    rst_n_i     = 1'b0;
    strobe_i    = 1'b0;
    idata_i     = 1'b0;
    qdata_i     = 1'b0;
    enable_i    = 1'b0;
    m_tready_i  = 1'b1;
    exp_cnt     = '0;
    ready_rand  = 1'b0;
    ovf_allowed = 1'b0;
    chk_reset   = 1'b1;
    chk_cnt     = 1'b0;
    update_head();

    repeat (4) tick();
    rst_n_i = 1'b1;
    tick();
    chk_reset = 1'b0;

    // plain data path with ready high
    for (int k = 0; k < 6; k++) begin
      s = rand_bits(DATA_W);
      push_expected(s);
      send_sample(s, `SSI_WORD_W, 1'b1);
    end
    wait_drain();
    check_count();

    // every other strobe sees enable low
    for (int k = 0; k < 6; k++) begin
      s = rand_bits(DATA_W);
      if (k % 2 == 1) push_expected(s);
      send_sample(s, `SSI_WORD_W, k % 2 == 1);
    end
    wait_drain();
    check_count();

    // random ready
    ready_rand = 1'b1;
    for (int k = 0; k < 8; k++) begin
      s = rand_bits(DATA_W);
      push_expected(s);
      send_sample(s, `SSI_WORD_W, 1'b1);
    end
    wait_drain();
    ready_rand = 1'b0;
    m_tready_i = 1'b1;
    check_count();

    // stalled output gets one sample more than the buffer holds
    m_tready_i  = 1'b0;
    ovf_allowed = 1'b1;
    for (int k = 0; k < `SSI_FIFO_DEPTH + 1; k++) begin
      s = rand_bits(DATA_W);
      if (k < `SSI_FIFO_DEPTH) push_expected(s);
      send_sample(s, `SSI_WORD_W, 1'b1);
    end
    wait_overflow();
    tick();
    m_tready_i = 1'b1;
    wait_drain();
    check_count();

    // strobe again partway through a word
    s = rand_bits(DATA_W);
    send_sample(s, 7, 1'b1);
    s = rand_bits(DATA_W);
    push_expected(s);
    send_sample(s, `SSI_WORD_W, 1'b1);
    wait_drain();
    check_count();

    $display("test passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
rtl/ssi_rx_pkg.sv
rtl/ssi_lane_deser.sv
rtl/ssi_sample_pack.sv
rtl/sample_fifo.sv
rtl/ssi_rx_top.sv
dv/tb_ssi_rx.sv

/* run.sh */
#!/bin/sh
# build and run the SSI receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_ssi_rx -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi

echo "pass line not found in sim.log"
exit 1
